/* verilog/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // word index bits of the data RAM, 4 KB in total
    localparam int RAM_ADDR_W = 10;
    localparam int RAM_WORDS  = 1 << RAM_ADDR_W;

    // memory operation carried from decode
    typedef enum logic [3:0] {
        LS_NONE = 4'd0,
        LB      = 4'd1,
        LBU     = 4'd2,
        LH      = 4'd3,
        LHU     = 4'd4,
        LW      = 4'd5,
        LWL     = 4'd6,
        LWR     = 4'd7,
        SB      = 4'd8,
        SH      = 4'd9,
        SW      = 4'd10,
        SWL     = 4'd11,
        SWR     = 4'd12
    } ls_sel_e;

    // one instruction leaving the execute stage
    typedef struct packed {
        logic [31:0] pc;
        // effective address for loads and stores
        logic [31:0] alu_res;
        logic [31:0] rt_data;
        logic        ls_ena;
        ls_sel_e     ls_sel;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        // 1 selects load data, 0 selects alu_res
        logic        wb_reg_sel;
        logic [1:0]  w_hilo_ena;
        logic [31:0] hi_res;
        logic [31:0] lo_res;
    } ex_mem_req_t;

    // record handed to writeback
    typedef struct packed {
        logic [31:0] pc;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic [31:0] w_reg_data;
        logic [1:0]  w_hilo_ena;
        logic [31:0] hi_res;
        logic [31:0] lo_res;
    } mem_wb_t;

    // one data RAM access
    typedef struct packed {
        logic                  en;
        logic [3:0]            wen;
        logic [RAM_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
    } ram_req_t;

endpackage

`default_nettype wire

/* verilog/pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload follows the input every cycle, valid tells whether it counts
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

    // a valid slot must carry a fully defined payload from the stage before
    a_payload_known: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(out_data)
    ) else $error("pipe_reg: unknown payload on a valid slot");

endmodule

`default_nettype wire

/* verilog/store_format.sv */
`timescale 1ns/100ps
`default_nettype none

module store_format (
    input  wire logic                 ex_valid,
    input  wire lsu_pkg::ex_mem_req_t ex_req,
    output lsu_pkg::ram_req_t         ram_req
);

    logic [1:0]  off;
    logic [31:0] rt;
    logic        ram_en;
    logic [3:0]  wen;
    logic [31:0] wdata;
    logic        misaligned;

    assign off    = ex_req.alu_res[1:0];
    assign rt     = ex_req.rt_data;
    assign ram_en = ex_valid & ex_req.ls_ena;

    // byte lane mask and lane placement of the store data
    always_comb begin
        wen   = 4'b0000;
        wdata = 32'h0000_0000;
        case (ex_req.ls_sel)
            lsu_pkg::SB: begin
                wen   = 4'b0001 << off;
                wdata = {4{rt[7:0]}};
            end
            lsu_pkg::SH: begin
                wen   = off[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt[15:0]}};
            end
            lsu_pkg::SW: begin
                wen   = 4'b1111;
                wdata = rt;
            end
            // lanes 0..off take the upper bytes of rt
            lsu_pkg::SWL: begin
                wen   = 4'b1111 >> (2'd3 - off);
                wdata = rt >> {(2'd3 - off), 3'b000};
            end
            // lanes off..3 take the lower bytes of rt
            lsu_pkg::SWR: begin
                wen   = 4'b1111 << off;
                wdata = rt << {off, 3'b000};
            end
            default: begin
                wen   = 4'b0000;
                wdata = 32'h0000_0000;
            end
        endcase
    end

    always_comb begin
        ram_req.en    = ram_en;
        ram_req.wen   = ram_en ? wen : 4'b0000;
        ram_req.addr  = ex_req.alu_res[lsu_pkg::RAM_ADDR_W+1:2];
        ram_req.wdata = wdata;
    end

    // no address exceptions here, execute must hand over aligned halves and words
    always_comb begin
        case (ex_req.ls_sel)
            lsu_pkg::LH,
            lsu_pkg::LHU,
            lsu_pkg::SH:  misaligned = off[0];
            lsu_pkg::LW,
            lsu_pkg::SW:  misaligned = (off != 2'b00);
            default:      misaligned = 1'b0;
        endcase
    end

    always_comb begin
        if (ram_en) begin
            a_aligned: assert final (!misaligned)
                else $error("store_format: misaligned access, sel %0d addr %h",
                            ex_req.ls_sel, ex_req.alu_res);
        end
    end

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_ram (
    input  wire logic              clk,
    input  wire lsu_pkg::ram_req_t ram_req,
    output logic [31:0]            rdata
);

    logic [31:0] mem [0:lsu_pkg::RAM_WORDS-1];

    // byte-masked write, old word goes to the read register
    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_req.wen[i]) begin
                    mem[ram_req.addr][8*i +: 8] <= ram_req.wdata[8*i +: 8];
                end
            end
            rdata <= mem[ram_req.addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/load_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module load_writeback (
    input  wire logic                 req_valid,
    input  wire lsu_pkg::ex_mem_req_t req,
    input  wire logic [31:0]          rdata,
    output logic                      wb_valid_next,
    output lsu_pkg::mem_wb_t          wb_next
);

    logic [1:0]  off;
    logic [31:0] rt;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] lwl_data;
    logic [31:0] lwr_data;
    logic [31:0] ld_data;
    logic        is_load;

    assign off = req.alu_res[1:0];
    assign rt  = req.rt_data;

    always_comb begin
        case (off)
            2'b00:   ld_byte = rdata[7:0];
            2'b01:   ld_byte = rdata[15:8];
            2'b10:   ld_byte = rdata[23:16];
            default: ld_byte = rdata[31:24];
        endcase
        ld_half = off[1] ? rdata[31:16] : rdata[15:0];
    end

    // LWL fills the top of rt from the low end of the word
    always_comb begin
        case (off)
            2'b00:   lwl_data = {rdata[7:0], rt[23:0]};
            2'b01:   lwl_data = {rdata[15:0], rt[15:0]};
            2'b10:   lwl_data = {rdata[23:0], rt[7:0]};
            default: lwl_data = rdata;
        endcase
    end

    // LWR fills the bottom of rt from byte off upward
    always_comb begin
        case (off)
            2'b00:   lwr_data = rdata;
            2'b01:   lwr_data = {rt[31:24], rdata[31:8]};
            2'b10:   lwr_data = {rt[31:16], rdata[31:16]};
            default: lwr_data = {rt[31:8], rdata[31:24]};
        endcase
    end

    always_comb begin
        ld_data = 32'h0000_0000;
        if (req.ls_ena) begin
            case (req.ls_sel)
                lsu_pkg::LB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
                lsu_pkg::LBU: ld_data = {24'h00_0000, ld_byte};
                lsu_pkg::LH:  ld_data = {{16{ld_half[15]}}, ld_half};
                lsu_pkg::LHU: ld_data = {16'h0000, ld_half};
                lsu_pkg::LW:  ld_data = rdata;
                lsu_pkg::LWL: ld_data = lwl_data;
                lsu_pkg::LWR: ld_data = lwr_data;
                default:      ld_data = 32'h0000_0000;
            endcase
        end
    end

    assign wb_valid_next = req_valid;

    always_comb begin
        wb_next.pc         = req.pc;
        wb_next.w_reg_ena  = req.w_reg_ena;
        wb_next.w_reg_dst  = req.w_reg_dst;
        wb_next.w_reg_data = req.wb_reg_sel ? ld_data : req.alu_res;
        wb_next.w_hilo_ena = req.w_hilo_ena;
        wb_next.hi_res     = req.hi_res;
        wb_next.lo_res     = req.lo_res;
    end

    assign is_load = req.ls_ena &&
                     (req.ls_sel inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH,
                                         lsu_pkg::LHU, lsu_pkg::LW, lsu_pkg::LWL,
                                         lsu_pkg::LWR});

    // decode may only route memory data to the register file for loads
    always_comb begin
        if (req_valid && req.wb_reg_sel) begin
            a_sel_load: assert final (is_load)
                else $error("load_writeback: wb_reg_sel set for sel %0d", req.ls_sel);
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 ex_valid,
    input  wire lsu_pkg::ex_mem_req_t ex_req,
    output logic                      wb_valid,
    output lsu_pkg::mem_wb_t          wb
);

    lsu_pkg::ram_req_t    ram_req;
    logic [31:0]          rdata;
    logic                 mem_valid;
    lsu_pkg::ex_mem_req_t mem_req;
    logic                 wb_valid_next;
    lsu_pkg::mem_wb_t     wb_next;

    store_format i_store_format (
        .ex_valid (ex_valid),
        .ex_req   (ex_req),
        .ram_req  (ram_req)
    );

    // RAM access and request capture happen on the same edge
    data_ram i_data_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (rdata)
    );

    pipe_reg #(
        .payload_t (lsu_pkg::ex_mem_req_t)
    ) i_ex_mem (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ex_valid),
        .in_data   (ex_req),
        .out_valid (mem_valid),
        .out_data  (mem_req)
    );

    load_writeback i_load_writeback (
        .req_valid     (mem_valid),
        .req           (mem_req),
        .rdata         (rdata),
        .wb_valid_next (wb_valid_next),
        .wb_next       (wb_next)
    );

    pipe_reg #(
        .payload_t (lsu_pkg::mem_wb_t)
    ) i_mem_wb (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (wb_valid_next),
        .in_data   (wb_next),
        .out_valid (wb_valid),
        .out_data  (wb)
    );

endmodule

`default_nettype wire

/* tests/tb_lsu_model.svh */
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// reference copy of the data RAM, only the test window is ever read
logic [31:0] ref_mem [0:lsu_pkg::RAM_WORDS-1];

// expected writeback records, the cycle each one is due and the test that issued it
lsu_pkg::mem_wb_t exp_q[$];
int               due_q[$];
string            name_q[$];

function automatic int word_index(input logic [31:0] addr);
    return int'(addr[lsu_pkg::RAM_ADDR_W+1:2]);
endfunction

function automatic void apply_store(input lsu_pkg::ex_mem_req_t req);
    int          k;
    int          widx;
    logic [31:0] w;
    logic [31:0] rt;
    k    = int'(req.alu_res[1:0]);
    widx = word_index(req.alu_res);
    w    = ref_mem[widx];
    rt   = req.rt_data;
    case (req.ls_sel)
        lsu_pkg::SB: w[8*k +: 8] = rt[7:0];
        // k is 0 or 2 here
        lsu_pkg::SH: w[8*k +: 16] = rt[15:0];
        lsu_pkg::SW: w = rt;
        // lane j takes rt byte j+3-k for lanes 0..k
        lsu_pkg::SWL: for (int j = 0; j <= k; j++) w[8*j +: 8] = rt[8*(j+3-k) +: 8];
        // lane j takes rt byte j-k for lanes k..3
        lsu_pkg::SWR: for (int j = k; j < 4; j++) w[8*j +: 8] = rt[8*(j-k) +: 8];
        default: ;
    endcase
    ref_mem[widx] = w;
endfunction

function automatic logic [31:0] predict_load(input lsu_pkg::ex_mem_req_t req);
    int          k;
    logic [31:0] w;
    logic [31:0] res;
    k   = int'(req.alu_res[1:0]);
    w   = ref_mem[word_index(req.alu_res)];
    res = req.rt_data;
    case (req.ls_sel)
        lsu_pkg::LB:  res = {{24{w[8*k+7]}}, w[8*k +: 8]};
        lsu_pkg::LBU: res = {24'h00_0000, w[8*k +: 8]};
        lsu_pkg::LH:  res = {{16{w[8*k+15]}}, w[8*k +: 16]};
        lsu_pkg::LHU: res = {16'h0000, w[8*k +: 16]};
        lsu_pkg::LW:  res = w;
        // memory bytes 0..k land at the top of rt
        lsu_pkg::LWL: for (int j = 0; j <= k; j++) res[8*(j+3-k) +: 8] = w[8*j +: 8];
        // memory bytes k..3 land at the bottom of rt
        lsu_pkg::LWR: for (int j = k; j < 4; j++) res[8*(j-k) +: 8] = w[8*j +: 8];
        default: res = 32'h0000_0000;
    endcase
    return res;
endfunction

function automatic lsu_pkg::mem_wb_t predict_wb(input lsu_pkg::ex_mem_req_t req);
    lsu_pkg::mem_wb_t exp;
    exp.pc         = req.pc;
    exp.w_reg_ena  = req.w_reg_ena;
    exp.w_reg_dst  = req.w_reg_dst;
    exp.w_reg_data = req.wb_reg_sel ? predict_load(req) : req.alu_res;
    exp.w_hilo_ena = req.w_hilo_ena;
    exp.hi_res     = req.hi_res;
    exp.lo_res     = req.lo_res;
    return exp;
endfunction

`endif

/* tests/tb_mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;

    localparam int RST_CYCLES  = 16;
    localparam int WIN_WORD    = 256;
    localparam int N_WORD      = 144;
    localparam int N_BYTE      = 72;
    localparam int N_UNALIGNED = 72;
    localparam int N_PASS      = 32;
    localparam int N_RANDOM    = 3000;
    // random gaps add at most one idle cycle per random instruction
    localparam int TIMEOUT_CYCLES = RST_CYCLES + N_WORD + N_BYTE + N_UNALIGNED + N_PASS
                                    + 2 * N_RANDOM + 2 + 20;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 ex_valid;
    lsu_pkg::ex_mem_req_t ex_req;
    logic                 wb_valid;
    lsu_pkg::mem_wb_t     wb;
    int                   cycle = 0;
    string                test_name;

    `include "tb_lsu_model.svh"

    mem_stage i_dut (
        .clk      (clk),
        .rst      (rst),
        .ex_valid (ex_valid),
        .ex_req   (ex_req),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout after %0d cycles, %0d outputs never arrived",
                                        cycle, exp_q.size()));
        end else begin
            cycle <= cycle + 1;
        end
    end

    function automatic logic [31:0] addr_of(input int word, input int off);
        return 32'((WIN_WORD + word) * 4 + off);
    endfunction

    function automatic lsu_pkg::ex_mem_req_t make_req(input lsu_pkg::ls_sel_e sel,
                                                      input logic [31:0] addr,
                                                      input logic [31:0] rt);
        lsu_pkg::ex_mem_req_t r;
        r.pc         = $urandom() & 32'hffff_fffc;
        r.alu_res    = addr;
        r.rt_data    = rt;
        r.ls_ena     = (sel != lsu_pkg::LS_NONE);
        r.ls_sel     = sel;
        r.wb_reg_sel = sel inside {[lsu_pkg::LB:lsu_pkg::LWR]};
        r.w_reg_ena  = r.wb_reg_sel ? 1'b1 : 1'($urandom_range(1));
        r.w_reg_dst  = 5'($urandom_range(31));
        r.w_hilo_ena = 2'($urandom_range(3));
        r.hi_res     = $urandom();
        r.lo_res     = $urandom();
        return r;
    endfunction

    function automatic lsu_pkg::ex_mem_req_t random_req();
        lsu_pkg::ls_sel_e sel;
        int               off;
        logic [31:0]      addr;
        sel = lsu_pkg::ls_sel_e'($urandom_range(12));
        off = $urandom_range(3);
        if (sel inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH}) off = off & 2;
        else if (sel inside {lsu_pkg::LW, lsu_pkg::SW}) off = 0;
        addr = addr_of($urandom_range(63), off);
        // bits above the RAM index wrap onto the same word
        addr[31:12] = 20'($urandom());
        if (sel == lsu_pkg::LS_NONE) addr = $urandom();
        return make_req(sel, addr, $urandom());
    endfunction

    task automatic check_outputs();
        lsu_pkg::mem_wb_t exp;
        int               due;
        string            name;
        if (wb_valid) begin
            assert (exp_q.size() != 0) else
                stop_with_failure($sformatf("unexpected output on wb in cycle %0d", cycle));
            exp  = exp_q.pop_front();
            due  = due_q.pop_front();
            name = name_q.pop_front();
            assert (cycle == due) else
                stop_with_failure($sformatf("** Error [%s] output cycle expected %0d actual %0d",
                                            name, due, cycle));
            assert (wb == exp) else
                stop_with_failure($sformatf("** Error [%s] expected %h actual %h",
                                            name, exp, wb));
        end else begin
            assert (due_q.size() == 0 || due_q[0] > cycle) else
                stop_with_failure($sformatf("[%s] output due in cycle %0d never showed up",
                                            name_q[0], due_q[0]));
        end
    endtask

    task automatic issue(input lsu_pkg::ex_mem_req_t req);
        @(negedge clk);
        check_outputs();
        ex_valid = 1'b1;
        ex_req   = req;
        exp_q.push_back(predict_wb(req));
        apply_store(req);
        due_q.push_back(cycle + 2);
        name_q.push_back(test_name);
    endtask

    task automatic bubble();
        @(negedge clk);
        check_outputs();
        ex_valid = 1'b0;
    endtask

    initial begin
        rst       = 1'b1;
        ex_valid  = 1'b1;
        ex_req    = '0;
        test_name = "reset_idle";
        void'($urandom(32'h0ca74e69));
        // valid instructions held during reset must never reach writeback
        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_outputs();
            ex_req = make_req(lsu_pkg::LS_NONE, $urandom(), $urandom());
        end
        rst      = 1'b0;
        ex_valid = 1'b0;

        // also fills the whole window so later loads never see unwritten words
        test_name = "word_roundtrip";
        for (int i = 0; i < 64; i++) begin
            issue(make_req(lsu_pkg::SW, addr_of(i, 0), $urandom()));
            if (i % 4 == 0) issue(make_req(lsu_pkg::LW, addr_of(i, 0), $urandom()));
        end
        for (int i = 0; i < 64; i++) issue(make_req(lsu_pkg::LW, addr_of(i, 0), $urandom()));

        test_name = "byte_half_extend";
        for (int w = 8; w < 12; w++) begin
            for (int k = 0; k < 4; k++) begin
                issue(make_req(lsu_pkg::SB, addr_of(w, k), $urandom()));
                issue(make_req(lsu_pkg::LB, addr_of(w, k), $urandom()));
                issue(make_req(lsu_pkg::LBU, addr_of(w, k), $urandom()));
            end
            for (int k = 0; k < 4; k += 2) begin
                issue(make_req(lsu_pkg::SH, addr_of(w, k), $urandom()));
                issue(make_req(lsu_pkg::LH, addr_of(w, k), $urandom()));
                issue(make_req(lsu_pkg::LHU, addr_of(w, k), $urandom()));
            end
        end

        test_name = "unaligned_pair";
        for (int k = 0; k < 4; k++) begin
            issue(make_req(lsu_pkg::SWL, addr_of(20, k), $urandom()));
            issue(make_req(lsu_pkg::SWR, addr_of(21, k), $urandom()));
            for (int j = 0; j < 4; j++) begin
                issue(make_req(lsu_pkg::LWL, addr_of(20, j), $urandom()));
                issue(make_req(lsu_pkg::LWR, addr_of(20, j), $urandom()));
                issue(make_req(lsu_pkg::LWL, addr_of(21, j), $urandom()));
                issue(make_req(lsu_pkg::LWR, addr_of(21, j), $urandom()));
            end
        end

        test_name = "passthrough";
        for (int i = 0; i < N_PASS; i++) begin
            issue(make_req(lsu_pkg::LS_NONE, $urandom(), $urandom()));
        end

        test_name = "random_stream";
        for (int i = 0; i < N_RANDOM; i++) begin
            if ($urandom_range(3) == 0) bubble();
            issue(random_req());
        end

        while (exp_q.size() != 0) bubble();
        // nothing may follow the last expected output
        repeat (2) bubble();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+tests
verilog/lsu_pkg.sv
verilog/pipe_reg.sv
verilog/store_format.sv
verilog/data_ram.sv
verilog/load_writeback.sv
verilog/mem_stage.sv
tests/tb_mem_stage.sv
